/* axis_correction.sv */
`timescale 1ns/1ps

module axis_correction
	import flight_pkg::*;
#(
	parameter axis_e AXIS = axis_pitch
)
(
	input logic clk,
	input logic rst,
	throttle_if.consumer tif,
	input stick_side_e side,
	input level_t level,
	output motor_offset_t motor_offset [4]
);

	logic [3:0] pair;
	motor_offset_t correction;

	// Bit i of the pair selects motor i + 1.
	always_comb
	begin
		pair = 4'b0000;
		case (AXIS)
			axis_pitch:
			begin
				if (side == side_low)
					pair = 4'b1010;
				else if (side == side_high)
					pair = 4'b0101;
			end
			axis_roll:
			begin
				if (side == side_low)
					pair = 4'b1001;
				else if (side == side_high)
					pair = 4'b0110;
			end
			axis_yaw:
			begin
				if (side == side_low)
					pair = 4'b0011;
				else if (side == side_high)
					pair = 4'b1100;
			end
			default:
			begin
				pair = 4'b0000;
			end
		endcase
	end

	assign correction = '0 - (motor_offset_t'(level) * CORRECTION_STEP);

	// Below spin the registers keep their last correction.
	always_ff @(posedge clk)
	begin
		for (int i = 0; i < 4; i++)
		begin
			if (rst)
			begin
				motor_offset[i] <= '0;
			end
			else if (tif.spin)
			begin
				motor_offset[i] <= pair[i] ? correction : '0;
			end
		end
	end

	a_center_zero: assert property (@(posedge clk) disable iff (rst)
		tif.spin && side == side_center |=>
			motor_offset[0] == '0 && motor_offset[1] == '0 &&
			motor_offset[2] == '0 && motor_offset[3] == '0);

endmodule

/* build.f */
+incdir+.
flight_pkg.sv
throttle_if.sv
throttle_band_decoder.sv
stick_quantizer.sv
throttle_command.sv
axis_correction.sv
status_leds.sv
flight_offset_core.sv
tb_flight_offset_core.sv

/* flight_offset_core.sv */
`timescale 1ns/1ps

module flight_offset_core
	import flight_pkg::*;
(
	input logic clk,
	input logic rst,
	input stick_t switch_state,
	input stick_t throttle,
	input stick_t pitch_stick,
	input stick_t roll_stick,
	input stick_t yaw_stick,
	output motor_offset_t throttle_offset [4],
	output motor_offset_t pitch_offset [4],
	output motor_offset_t roll_offset [4],
	output motor_offset_t yaw_offset [4],
	output logic [7:0] led
);

	stick_side_e pitch_side;
	stick_side_e roll_side;
	stick_side_e yaw_side;
	level_t pitch_level;
	level_t roll_level;
	level_t yaw_level;

	throttle_if tif ();

	// Decode stage.
	throttle_band_decoder i_throttle_band_decoder
	(
		.switch_state(switch_state),
		.throttle(throttle),
		.tif(tif)
	);

	stick_quantizer i_pitch_quantizer
	(
		.stick(pitch_stick),
		.side(pitch_side),
		.level(pitch_level)
	);

	stick_quantizer i_roll_quantizer
	(
		.stick(roll_stick),
		.side(roll_side),
		.level(roll_level)
	);

	stick_quantizer i_yaw_quantizer
	(
		.stick(yaw_stick),
		.side(yaw_side),
		.level(yaw_level)
	);

	// Execute stage with one register per source.
	throttle_command i_throttle_command
	(
		.clk(clk),
		.rst(rst),
		.tif(tif),
		.motor_offset(throttle_offset)
	);

	axis_correction #(.AXIS(axis_pitch)) i_pitch_correction
	(
		.clk(clk),
		.rst(rst),
		.tif(tif),
		.side(pitch_side),
		.level(pitch_level),
		.motor_offset(pitch_offset)
	);

	axis_correction #(.AXIS(axis_roll)) i_roll_correction
	(
		.clk(clk),
		.rst(rst),
		.tif(tif),
		.side(roll_side),
		.level(roll_level),
		.motor_offset(roll_offset)
	);

	axis_correction #(.AXIS(axis_yaw)) i_yaw_correction
	(
		.clk(clk),
		.rst(rst),
		.tif(tif),
		.side(yaw_side),
		.level(yaw_level),
		.motor_offset(yaw_offset)
	);

	status_leds i_status_leds
	(
		.clk(clk),
		.rst(rst),
		.tif(tif),
		.led(led)
	);

endmodule

/* flight_pkg.sv */
package flight_pkg;

	// Stick, throttle and switch inputs are all raw 8-bit values.
	typedef logic [7:0] stick_t;

	// Motor offsets are 11-bit two's complement and wrap modulo 2048.
	typedef logic [10:0] motor_offset_t;

	typedef logic [3:0] level_t; // Correction level from 0 to 10.
	typedef logic [3:0] band_t;  // Throttle band from 0 to 8.

	typedef enum logic
	{
		mode_armed,
		mode_safe
	} arm_mode_e;

	typedef enum logic [1:0]
	{
		side_low,
		side_center,
		side_high
	} stick_side_e;

	typedef enum logic [1:0]
	{
		axis_pitch,
		axis_roll,
		axis_yaw
	} axis_e;

	localparam motor_offset_t THROTTLE_GAIN = 11'd10;
	localparam motor_offset_t THROTTLE_BIAS = 11'd100;
	localparam motor_offset_t SAFE_OFFSET = motor_offset_t'(-50); // 11'h7CE.
	localparam motor_offset_t CORRECTION_STEP = 11'd5;

	// Armed while the switch reads below this value.
	localparam stick_t ARM_LIMIT = 8'd25;

	// Attitude corrections only update above this throttle.
	localparam stick_t SPIN_LIMIT = 8'd5;

	localparam int THROTTLE_BANDS = 9;
	localparam int STICK_LEVELS = 10;

	// The band is the index of the first bound that is not below the throttle.
	localparam stick_t THROTTLE_BAND_TOP [THROTTLE_BANDS] = '{
		8'd2, 8'd5, 8'd10, 8'd15, 8'd20, 8'd25, 8'd30, 8'd35, 8'd255
	};

	// Entry i covers the low side at level 10 - i.
	localparam stick_t STICK_LOW_TOP [STICK_LEVELS] = '{
		8'd2, 8'd4, 8'd6, 8'd8, 8'd10, 8'd12, 8'd14, 8'd16, 8'd18, 8'd19
	};

	localparam stick_t STICK_CENTER = 8'd20;

	// Entry i starts the high side at level i + 1.
	localparam stick_t STICK_HIGH_BOTTOM [STICK_LEVELS] = '{
		8'd21, 8'd22, 8'd25, 8'd27, 8'd29, 8'd31, 8'd33, 8'd35, 8'd37, 8'd39
	};

	// LEDs 2, 4, 6 and 8 are lit with LED 1 in bit 0.
	localparam logic [7:0] SAFE_LED_PATTERN = 8'b1010_1010;

endpackage

/* run_sim.sh */
#!/bin/sh
# Compiles and runs the testbench with Verilator from the project root.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module tb_flight_offset_core \
	-o sim_flight > build.log 2>&1 \
	&& ./obj_dir/sim_flight > sim.log 2>&1 \
	|| echo "Simulation failed" >> sim.log

cat build.log sim.log
grep -q "Simulation failed" sim.log && exit 1 || exit 0

/* status_leds.sv */
`timescale 1ns/1ps

module status_leds
	import flight_pkg::*;
(
	input logic clk,
	input logic rst,
	throttle_if.consumer tif,
	output logic [7:0] led
);

	logic [7:0] bar;

	// Band 0 lights all eight LEDs, band 8 none.
	assign bar = 8'hff >> tif.band;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			led <= '0;
		end
		else if (tif.mode == mode_armed)
		begin
			led <= bar;
		end
		else
		begin
			led <= SAFE_LED_PATTERN;
		end
	end

	a_bar_limit: assert property (@(posedge clk) disable iff (rst)
		tif.mode == mode_armed |=> $countones(led) <= 8 - int'($past(tif.band)));

endmodule

/* stick_quantizer.sv */
`timescale 1ns/1ps

module stick_quantizer
	import flight_pkg::*;
(
	input stick_t stick,
	output stick_side_e side,
	output level_t level
);

	always_comb
	begin
		side = side_center;
		level = '0;
		if (stick < STICK_CENTER)
		begin
			side = side_low;
			// The smallest matching bound gives the strongest correction.
			for (int i = STICK_LEVELS - 1; i >= 0; i--)
			begin
				if (stick <= STICK_LOW_TOP[i])
				begin
					level = level_t'(STICK_LEVELS - i);
				end
			end
		end
		else if (stick > STICK_CENTER)
		begin
			side = side_high;
			for (int i = 0; i < STICK_LEVELS; i++)
			begin
				if (stick >= STICK_HIGH_BOTTOM[i])
				begin
					level = level_t'(i + 1); // Highest bound reached.
				end
			end
		end
	end

endmodule

/* tb_flight_ref.svh */
`ifndef TB_FLIGHT_REF_SVH
`define TB_FLIGHT_REF_SVH

// Fibonacci step with taps 32, 22, 2 and 1.
function automatic logic [31:0] lfsr_step(input logic [31:0] state);
	return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
endfunction

// One LFSR step for every bit that goes into the value.
function automatic logic [7:0] random_bits(input int count);
	logic [7:0] value;
	value = '0;
	for (int i = 0; i < count; i++)
	begin
		lfsr_state = lfsr_step(lfsr_state);
		value = {value[6:0], lfsr_state[0]};
	end
	return value;
endfunction

function automatic int throttle_band(input logic [7:0] thr);
	int tops [9] = '{2, 5, 10, 15, 20, 25, 30, 35, 255};
	for (int i = 0; i < 9; i++)
		if (int'(thr) <= tops[i])
			return i;
	return 8;
endfunction

function automatic logic [10:0] expected_throttle(input logic [7:0] sw, input logic [7:0] thr);
	int value;
	if (sw >= 8'd25)
		return 11'h7ce; // Minus 50 in 11 bits.
	value = int'(thr) * 10;
	if (throttle_band(thr) != 0)
		value = value + 100;
	return 11'(value);
endfunction

function automatic logic [7:0] expected_leds(input logic [7:0] sw, input logic [7:0] thr);
	logic [7:0] bar;
	if (sw >= 8'd25)
		return 8'b1010_1010;
	bar = '0;
	for (int i = 0; i < 8 - throttle_band(thr); i++)
		bar[i] = 1'b1;
	return bar;
endfunction

// Negative levels mean the low side, positive ones the high side.
function automatic int stick_level(input logic [7:0] stick);
	int low_top [10] = '{2, 4, 6, 8, 10, 12, 14, 16, 18, 19};
	int high_bottom [10] = '{21, 22, 25, 27, 29, 31, 33, 35, 37, 39};
	for (int i = 0; i < 10; i++)
		if (int'(stick) <= low_top[i])
			return i - 10;
	for (int i = 9; i >= 0; i--)
		if (int'(stick) >= high_bottom[i])
			return i + 1;
	return 0;
endfunction

// Axis 0 is pitch, 1 roll and 2 yaw; motors count from 1.
function automatic bit motor_in_pair(input int axis, input bit high, input int motor);
	case (axis)
		0: return high ? (motor == 1 || motor == 3) : (motor == 2 || motor == 4);
		1: return high ? (motor == 2 || motor == 3) : (motor == 1 || motor == 4);
		default: return high ? (motor == 3 || motor == 4) : (motor == 1 || motor == 2);
	endcase
endfunction

function automatic logic [10:0] expected_correction(input int axis, input logic [7:0] stick,
		input int motor);
	int level;
	level = stick_level(stick);
	if (level == 0 || !motor_in_pair(axis, level > 0, motor))
		return '0;
	return 11'(-5 * (level < 0 ? -level : level));
endfunction

task automatic check_value(input string name, input logic [10:0] got, input logic [10:0] expected);
	test_checks++;
	if (got !== expected)
	begin
		test_errors++;
		$display("Error at %0t: %s expected %h, got %h", $time, name, expected, got);
	end
endtask

`endif

/* tb_flight_offset_core.sv */
`timescale 1ns/1ps

module tb_flight_offset_core;

	// About 2,070 stimulus cycles with a margin of 200 on top.
	localparam int TIMEOUT_CYCLES = 2270;

	logic clk;
	logic rst;
	logic reset_on;
	logic [7:0] switch_state, throttle, pitch_stick, roll_stick, yaw_stick;
	logic [10:0] throttle_offset [4];
	logic [10:0] pitch_offset [4];
	logic [10:0] roll_offset [4];
	logic [10:0] yaw_offset [4];
	logic [7:0] led;

	logic [10:0] exp_throttle [4];
	logic [10:0] exp_axis [3][4]; // Also the hold value of each axis.
	logic [7:0] exp_led;
	logic compare_en;
	logic [31:0] lfsr_state;
	int test_checks, test_errors, total_checks, total_errors, tests_run, cycles;

	`include "tb_flight_ref.svh"

	flight_offset_core i_flight_offset_core
	(
		.clk(clk),
		.rst(rst),
		.switch_state(switch_state),
		.throttle(throttle),
		.pitch_stick(pitch_stick),
		.roll_stick(roll_stick),
		.yaw_stick(yaw_stick),
		.throttle_offset(throttle_offset),
		.pitch_offset(pitch_offset),
		.roll_offset(roll_offset),
		.yaw_offset(yaw_offset),
		.led(led)
	);

	always #20 clk = ~clk;

	task automatic predict();
		logic [7:0] sticks [3];
		sticks[0] = pitch_stick;
		sticks[1] = roll_stick;
		sticks[2] = yaw_stick;
		exp_led = rst ? 8'h00 : expected_leds(switch_state, throttle);
		for (int m = 0; m < 4; m++)
		begin
			exp_throttle[m] = rst ? 11'h000 : expected_throttle(switch_state, throttle);
			for (int a = 0; a < 3; a++)
			begin
				if (rst)
					exp_axis[a][m] = '0;
				else if (throttle > 8'd5)
					exp_axis[a][m] = expected_correction(a, sticks[a], m + 1);
			end
		end
	endtask

	task automatic apply(input logic [7:0] sw, input logic [7:0] thr, input logic [7:0] p,
			input logic [7:0] r, input logic [7:0] y);
		@(negedge clk);
		rst = reset_on;
		switch_state = sw;
		throttle = thr;
		pitch_stick = p;
		roll_stick = r;
		yaw_stick = y;
		predict();
		compare_en = 1'b1;
	endtask

	task automatic compare_outputs();
		for (int m = 0; m < 4; m++)
		begin
			check_value($sformatf("throttle_offset[%0d]", m), throttle_offset[m], exp_throttle[m]);
			check_value($sformatf("pitch_offset[%0d]", m), pitch_offset[m], exp_axis[0][m]);
			check_value($sformatf("roll_offset[%0d]", m), roll_offset[m], exp_axis[1][m]);
			check_value($sformatf("yaw_offset[%0d]", m), yaw_offset[m], exp_axis[2][m]);
		end
		check_value("led", {3'b000, led}, {3'b000, exp_led});
	endtask

	// Waits until the last stimulus of the test has been compared.
	task automatic finish_test(input string name);
		@(posedge clk);
		#10;
		$display("Test %s: %0d checks, %0d errors", name, test_checks, test_errors);
		total_checks += test_checks;
		total_errors += test_errors;
		tests_run++;
		test_checks = 0;
		test_errors = 0;
	endtask

	// Outputs settle after the rising edge, long before the next falling edge.
	always @(posedge clk)
	begin
		#5;
		if (compare_en)
			compare_outputs();
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: the tests did not end within %0d cycles.", TIMEOUT_CYCLES);
			$display("Simulation failed");
			$finish;
		end
	end

	initial
	begin
		logic [7:0] rnd [5];
		clk = 1'b1; // First edge is a falling one.
		rst = 1'b1;
		reset_on = 1'b1;
		switch_state = 8'd0;
		throttle = 8'd100;
		pitch_stick = 8'd0;
		roll_stick = 8'd0;
		yaw_stick = 8'd0;
		compare_en = 1'b0;
		lfsr_state = 32'hc208_970b;

		repeat (4)
			apply(8'd0, 8'd100, 8'd0, 8'd0, 8'd0);
		finish_test("reset");
		reset_on = 1'b0;

		for (int t = 0; t < 256; t++)
			apply(8'd0, 8'(t), 8'd20, 8'd20, 8'd20);
		finish_test("armed throttle sweep");

		for (int t = 0; t < 256; t++)
		begin
			apply(8'd25, 8'(t), 8'd20, 8'd20, 8'd20);
			apply(8'd255, 8'(t), 8'd20, 8'd20, 8'd20);
		end
		finish_test("safe mode");

		for (int s = 0; s < 256; s++)
			apply(8'd0, 8'd20, 8'(s), 8'd20, 8'd20);
		for (int s = 0; s < 256; s++)
			apply(8'd0, 8'd20, 8'd20, 8'(s), 8'd20);
		for (int s = 0; s < 256; s++)
			apply(8'd0, 8'd20, 8'd20, 8'd20, 8'(s));
		finish_test("axis sweeps");

		apply(8'd0, 8'd20, 8'd3, 8'd30, 8'd45);
		for (int i = 0; i < 24; i++)
			apply(8'd0, 8'(i % 6), 8'(i * 10), 8'(255 - i * 7), 8'(i * 3));
		finish_test("hold");

		for (int n = 0; n < 500; n++)
		begin
			rnd[0] = random_bits(6); // Narrow values reach both modes and all stick levels.
			rnd[1] = random_bits(8);
			rnd[2] = random_bits(6);
			rnd[3] = random_bits(6);
			rnd[4] = random_bits(6);
			apply(rnd[0], rnd[1], rnd[2], rnd[3], rnd[4]);
		end
		finish_test("random");

		$display("Summary: %0d tests, %0d checks, %0d errors", tests_run, total_checks,
			total_errors);
		if (total_errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

/* throttle_band_decoder.sv */
`timescale 1ns/1ps

module throttle_band_decoder
	import flight_pkg::*;
(
	input stick_t switch_state,
	input stick_t throttle,
	throttle_if.decoder tif
);

	band_t band;

	// Walk the table from the top so that the lowest matching bound wins.
	always_comb
	begin
		band = band_t'(THROTTLE_BANDS - 1);
		for (int i = THROTTLE_BANDS - 1; i >= 0; i--)
		begin
			if (throttle <= THROTTLE_BAND_TOP[i])
			begin
				band = band_t'(i);
			end
		end
	end

	assign tif.band = band;
	assign tif.mode = (switch_state < ARM_LIMIT) ? mode_armed : mode_safe;
	assign tif.spin = (throttle > SPIN_LIMIT);
	assign tif.throttle = throttle;

endmodule

/* throttle_command.sv */
`timescale 1ns/1ps

module throttle_command
	import flight_pkg::*;
(
	input logic clk,
	input logic rst,
	throttle_if.consumer tif,
	output motor_offset_t motor_offset [4]
);

	motor_offset_t armed_offset;

	// The lowest band gets the plain gain, every other band the bias as well.
	always_comb
	begin
		armed_offset = motor_offset_t'(tif.throttle) * THROTTLE_GAIN;
		if (tif.band != '0)
		begin
			armed_offset = armed_offset + THROTTLE_BIAS;
		end
	end

	always_ff @(posedge clk)
	begin
		for (int i = 0; i < 4; i++)
		begin
			if (rst)
			begin
				motor_offset[i] <= '0;
			end
			else
			begin
				motor_offset[i] <= (tif.mode == mode_armed) ? armed_offset : SAFE_OFFSET;
			end
		end
	end

	a_safe_offset: assert property (@(posedge clk) disable iff (rst)
		tif.mode == mode_safe |=>
			motor_offset[0] == SAFE_OFFSET && motor_offset[1] == SAFE_OFFSET &&
			motor_offset[2] == SAFE_OFFSET && motor_offset[3] == SAFE_OFFSET);

endmodule

/* throttle_if.sv */
`timescale 1ns/1ps

interface throttle_if
	import flight_pkg::*;
();

	arm_mode_e mode;
	band_t band;
	bit spin; // Throttle above SPIN_LIMIT.
	stick_t throttle;

	modport decoder
	(
		output mode,
		output band,
		output spin,
		output throttle
	);

	modport consumer
	(
		input mode,
		input band,
		input spin,
		input throttle
	);

endinterface
